//--- source/host_link_pkg.sv
package host_link_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [4:0] idx_t;
	typedef logic signed [23:0] vcxo_err_t;
	typedef logic [5:0] dac_flags_t;
	typedef logic [10:0] cic_rate_t;

	typedef enum logic [2:0]
	{
		IDLE,
		WR_PARAMS,
		RD_STATUS,
		WR_TX_IQ,
		BUS_ECHO,
		RD_INFO
	} link_state_t;

	// Opcodes seen with the sync strobe
	localparam byte_t OP_BUS_TEST = 8'd0;
	localparam byte_t OP_SET_PARAMS = 8'd1;
	localparam byte_t OP_GET_STATUS = 8'd2;
	localparam byte_t OP_TX_IQ = 8'd3;
	localparam byte_t OP_GET_INFO = 8'd8;

	localparam idx_t LEN_PARAMS = 5'd20;
	localparam idx_t LEN_STATUS = 5'd8;
	localparam idx_t LEN_TX_IQ = 5'd8;
	localparam idx_t LEN_INFO = 5'd3;

	localparam word_t DEF_NCO_FREQ = 32'd242347;
	localparam byte_t DEF_GAIN = 8'd32;
	localparam byte_t DEF_CTRL_FLAGS = 8'b0001_0001; // rx1 and adc_shdn
	localparam cic_rate_t DEF_CIC_RATE = 11'd640;

	localparam byte_t INFO_BYTE0 = 8'd2;
	localparam byte_t INFO_BYTE1 = 8'd3;
	localparam byte_t INFO_BYTE2 = 8'd4;

	localparam sample_t PEAK_MIN_INIT = 16'sd32000;
	localparam sample_t PEAK_MAX_INIT = -16'sd32000;

	// Indexed by the 2-bit rate code
	localparam cic_rate_t CIC_RATE_TAB [0:3] = '{11'd160, 11'd320, 11'd640, 11'd1280};

endpackage

//--- source/host_cmd_fsm.sv
`timescale 1ns/100ps

module host_cmd_fsm
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input logic bus_sync,
	input byte_t bus_in,
	input logic last,
	input logic snap_ack,
	output link_state_t state,
	output logic active,
	output idx_t cmd_len,
	output logic snap_req
);

	logic start_status;
	logic snap_pend;
	logic issue;

	assign start_status = bus_sync && (bus_in == OP_GET_STATUS);
	assign issue = !snap_req && !snap_ack && (start_status || snap_pend);
	assign active = (state != IDLE);

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			state <= IDLE;
			cmd_len <= '0;
		end
		else if (bus_sync) // New command, also aborts the old one
		begin
			case (bus_in)
				OP_BUS_TEST:
				begin
					state <= BUS_ECHO;
					cmd_len <= '0; // Unbounded
				end
				OP_SET_PARAMS:
				begin
					state <= WR_PARAMS;
					cmd_len <= LEN_PARAMS;
				end
				OP_GET_STATUS:
				begin
					state <= RD_STATUS;
					cmd_len <= LEN_STATUS;
				end
				OP_TX_IQ:
				begin
					state <= WR_TX_IQ;
					cmd_len <= LEN_TX_IQ;
				end
				OP_GET_INFO:
				begin
					state <= RD_INFO;
					cmd_len <= LEN_INFO;
				end
				default:
				begin
					state <= IDLE;
					cmd_len <= '0;
				end
			endcase
		end
		else if (last && (state != BUS_ECHO))
			state <= IDLE;
	end

	// Requesting side of the snapshot handshake
	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			snap_req <= 1'b0;
			snap_pend <= 1'b0;
		end
		else
		begin
			if (snap_req && snap_ack)
				snap_req <= 1'b0;
			else if (issue)
				snap_req <= 1'b1;
			snap_pend <= (snap_pend || start_status) && !issue; // Wait for ack low
		end
	end

	a_req_after_ack_low : assert property (@(posedge adcclk_in)
		disable iff (ADC_MINMAX_RESET) $rose(snap_req) |-> !$past(snap_ack));

endmodule

//--- source/byte_counter.sv
`timescale 1ns/100ps

module byte_counter
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input logic bus_sync,
	input logic active,
	input idx_t cmd_len,
	output idx_t byte_idx,
	output logic last
);

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
			byte_idx <= '0;
		else if (bus_sync)
			byte_idx <= '0;
		else if (active)
			byte_idx <= byte_idx + 5'd1; // Wraps during bus test
	end

	// Terminal index of the current command
	assign last = active && (byte_idx == idx_t'(cmd_len - 5'd1));

endmodule

//--- source/control_regs.sv
`timescale 1ns/100ps

module control_regs
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input logic bus_sync,
	input byte_t bus_in,
	input link_state_t state,
	input idx_t byte_idx,
	output byte_t ctrl_flags,
	output word_t nco1_freq,
	output word_t nco2_freq,
	output word_t tx_nco_freq,
	output byte_t cicfir_gain,
	output byte_t tx_cicfir_gain,
	output byte_t dac_gain,
	output sample_t adc_offset,
	output byte_t vcxo_correction,
	output dac_flags_t dac_flags,
	output cic_rate_t rx_cic_rate,
	output word_t tx_i,
	output word_t tx_q,
	output logic tx_iq_valid
);

	// Replace one byte of a word, pos 0 is the MSB
	function automatic word_t set_byte(input word_t w, input logic [1:0] pos, input byte_t b);
		word_t r;
		r = w;
		r[(3 - pos) * 8 +: 8] = b;
		return r;
	endfunction

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			ctrl_flags <= DEF_CTRL_FLAGS;
			nco1_freq <= DEF_NCO_FREQ;
			nco2_freq <= DEF_NCO_FREQ;
			tx_nco_freq <= DEF_NCO_FREQ;
			cicfir_gain <= DEF_GAIN;
			tx_cicfir_gain <= DEF_GAIN;
			dac_gain <= DEF_GAIN;
			adc_offset <= '0;
			vcxo_correction <= '0;
			dac_flags <= '0;
			rx_cic_rate <= DEF_CIC_RATE;
			tx_i <= '0;
			tx_q <= '0;
			tx_iq_valid <= 1'b0;
		end
		else if (bus_sync)
		begin
			if (bus_in == OP_TX_IQ)
				tx_iq_valid <= 1'b0; // Sample pair being replaced
		end
		else if (state == WR_PARAMS)
		begin
			case (byte_idx)
				5'd0:
				begin
					ctrl_flags <= bus_in;
					if (!bus_in[2]) // TX off flushes the TX chain
					begin
						tx_i <= '0;
						tx_q <= '0;
						tx_iq_valid <= 1'b1;
					end
				end
				5'd1, 5'd2, 5'd3, 5'd4: nco1_freq <= set_byte(nco1_freq, 2'(byte_idx - 5'd1), bus_in);
				5'd5, 5'd6, 5'd7, 5'd8: nco2_freq <= set_byte(nco2_freq, 2'(byte_idx - 5'd5), bus_in);
				5'd9: cicfir_gain <= bus_in;
				5'd10: tx_cicfir_gain <= bus_in;
				5'd11: dac_gain <= bus_in;
				5'd12: adc_offset[15:8] <= bus_in;
				5'd13: adc_offset[7:0] <= bus_in;
				5'd14: vcxo_correction <= bus_in;
				5'd15:
				begin
					dac_flags <= bus_in[5:0];
					rx_cic_rate <= CIC_RATE_TAB[bus_in[7:6]];
				end
				5'd16, 5'd17, 5'd18, 5'd19: tx_nco_freq <= set_byte(tx_nco_freq, byte_idx[1:0], bus_in);
				default: ;
			endcase
		end
		else if (state == WR_TX_IQ)
		begin
			if (byte_idx[2]) // Q first, then I
				tx_i <= set_byte(tx_i, byte_idx[1:0], bus_in);
			else
				tx_q <= set_byte(tx_q, byte_idx[1:0], bus_in);
			if (byte_idx == 5'd7)
				tx_iq_valid <= 1'b1;
		end
	end

endmodule

//--- source/adc_peak_tracker.sv
`timescale 1ns/100ps

module adc_peak_tracker
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input sample_t adc_in,
	input logic snap_req,
	output logic snap_ack,
	output sample_t snap_min,
	output sample_t snap_max
);

	sample_t cur_min;
	sample_t cur_max;
	logic take;

	assign take = snap_req && !snap_ack;

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			cur_min <= PEAK_MIN_INIT;
			cur_max <= PEAK_MAX_INIT;
			snap_ack <= 1'b0;
		end
		else if (take)
		begin
			// New window starts from this sample
			cur_min <= adc_in;
			cur_max <= adc_in;
			snap_ack <= 1'b1;
		end
		else
		begin
			if (!snap_req)
				snap_ack <= 1'b0;
			if (adc_in < cur_min)
				cur_min <= adc_in;
			if (adc_in > cur_max)
				cur_max <= adc_in;
		end
	end

	always_ff @(posedge adcclk_in)
	begin
		if (take)
		begin
			snap_min <= cur_min; // Window up to the previous edge
			snap_max <= cur_max;
		end
	end

	a_ack_needs_req : assert property (@(posedge adcclk_in)
		disable iff (ADC_MINMAX_RESET) $rose(snap_ack) |-> $past(snap_req));

endmodule

//--- source/readback_mux.sv
`timescale 1ns/100ps

module readback_mux
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input link_state_t state,
	input idx_t byte_idx,
	input byte_t bus_in,
	input logic adc_otr,
	input logic dac_otr,
	input sample_t snap_min,
	input sample_t snap_max,
	input vcxo_err_t vcxo_err,
	output byte_t bus_out,
	output logic bus_oe
);

	byte_t status_byte;
	byte_t info_byte;

	always_comb
	begin
		case (byte_idx)
			5'd0: status_byte = {6'b0, dac_otr, adc_otr};
			5'd1: status_byte = snap_min[15:8];
			5'd2: status_byte = snap_min[7:0];
			5'd3: status_byte = snap_max[15:8];
			5'd4: status_byte = snap_max[7:0];
			5'd5: status_byte = vcxo_err[23:16];
			5'd6: status_byte = vcxo_err[15:8];
			default: status_byte = vcxo_err[7:0];
		endcase
		case (byte_idx)
			5'd0: info_byte = INFO_BYTE0;
			5'd1: info_byte = INFO_BYTE1;
			default: info_byte = INFO_BYTE2;
		endcase
	end

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
			bus_oe <= 1'b0;
		else
			bus_oe <= (state == RD_STATUS) || (state == RD_INFO) ||
				((state == BUS_ECHO) && !byte_idx[0]); // Drive in the odd slot
	end

	always_ff @(posedge adcclk_in)
	begin
		case (state)
			RD_STATUS: bus_out <= status_byte;
			RD_INFO: bus_out <= info_byte;
			BUS_ECHO:
				if (!byte_idx[0])
					bus_out <= bus_in; // Held through the odd index
			default: ;
		endcase
	end

endmodule

//--- source/host_link_top.sv
`timescale 1ns/100ps

module host_link_top
	import host_link_pkg::*;
(
	input logic adcclk_in,
	input logic ADC_MINMAX_RESET,
	input logic bus_sync,
	input byte_t bus_in,
	input sample_t adc_in,
	input logic adc_otr,
	input logic dac_otr,
	input vcxo_err_t vcxo_err,
	output byte_t bus_out,
	output logic bus_oe,
	output byte_t ctrl_flags,
	output word_t nco1_freq,
	output word_t nco2_freq,
	output word_t tx_nco_freq,
	output byte_t cicfir_gain,
	output byte_t tx_cicfir_gain,
	output byte_t dac_gain,
	output sample_t adc_offset,
	output byte_t vcxo_correction,
	output dac_flags_t dac_flags,
	output cic_rate_t rx_cic_rate,
	output word_t tx_i,
	output word_t tx_q,
	output logic tx_iq_valid
);

	link_state_t state;
	logic active;
	idx_t cmd_len;
	idx_t byte_idx;
	logic last;
	logic snap_req;
	logic snap_ack;
	sample_t snap_min;
	sample_t snap_max;

	host_cmd_fsm u_fsm
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.bus_sync(bus_sync),
		.bus_in(bus_in),
		.last(last),
		.snap_ack(snap_ack),
		.state(state),
		.active(active),
		.cmd_len(cmd_len),
		.snap_req(snap_req)
	);

	byte_counter u_cnt
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.bus_sync(bus_sync),
		.active(active),
		.cmd_len(cmd_len),
		.byte_idx(byte_idx),
		.last(last)
	);

	control_regs u_regs
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.bus_sync(bus_sync),
		.bus_in(bus_in),
		.state(state),
		.byte_idx(byte_idx),
		.ctrl_flags(ctrl_flags),
		.nco1_freq(nco1_freq),
		.nco2_freq(nco2_freq),
		.tx_nco_freq(tx_nco_freq),
		.cicfir_gain(cicfir_gain),
		.tx_cicfir_gain(tx_cicfir_gain),
		.dac_gain(dac_gain),
		.adc_offset(adc_offset),
		.vcxo_correction(vcxo_correction),
		.dac_flags(dac_flags),
		.rx_cic_rate(rx_cic_rate),
		.tx_i(tx_i),
		.tx_q(tx_q),
		.tx_iq_valid(tx_iq_valid)
	);

	adc_peak_tracker u_peak
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.adc_in(adc_in),
		.snap_req(snap_req),
		.snap_ack(snap_ack),
		.snap_min(snap_min),
		.snap_max(snap_max)
	);

	readback_mux u_rdmux
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.state(state),
		.byte_idx(byte_idx),
		.bus_in(bus_in),
		.adc_otr(adc_otr),
		.dac_otr(dac_otr),
		.snap_min(snap_min),
		.snap_max(snap_max),
		.vcxo_err(vcxo_err),
		.bus_out(bus_out),
		.bus_oe(bus_oe)
	);

endmodule

//--- test/host_link_tb.sv
`timescale 1ns/100ps

module host_link_tb
	import host_link_pkg::*;
();

	logic adcclk_in;
	logic ADC_MINMAX_RESET;
	logic bus_sync;
	byte_t bus_in;
	sample_t adc_in;
	logic adc_otr;
	logic dac_otr;
	vcxo_err_t vcxo_err;
	byte_t bus_out;
	logic bus_oe;
	byte_t ctrl_flags;
	word_t nco1_freq;
	word_t nco2_freq;
	word_t tx_nco_freq;
	byte_t cicfir_gain;
	byte_t tx_cicfir_gain;
	byte_t dac_gain;
	sample_t adc_offset;
	byte_t vcxo_correction;
	dac_flags_t dac_flags;
	cic_rate_t rx_cic_rate;
	word_t tx_i;
	word_t tx_q;
	logic tx_iq_valid;

	// Reference model
	byte_t e_flags;
	word_t e_nco1;
	word_t e_nco2;
	word_t e_txnco;
	byte_t e_cicfir;
	byte_t e_txgain;
	byte_t e_dacgain;
	sample_t e_offset;
	byte_t e_vcxo;
	dac_flags_t e_dacflags;
	cic_rate_t e_cic;
	word_t e_txi;
	word_t e_txq;
	logic e_valid;
	logic e_oe;
	byte_t e_out;
	link_state_t m_state;
	idx_t m_idx;
	idx_t m_len;
	sample_t w_min;
	sample_t w_max;
	sample_t s_min;
	sample_t s_max;
	logic snap_next;

	byte_t payload [0:19];
	integer seed;
	int errors;
	int timeouts;
	string test_name;

	host_link_top uut
	(
		.adcclk_in(adcclk_in),
		.ADC_MINMAX_RESET(ADC_MINMAX_RESET),
		.bus_sync(bus_sync),
		.bus_in(bus_in),
		.adc_in(adc_in),
		.adc_otr(adc_otr),
		.dac_otr(dac_otr),
		.vcxo_err(vcxo_err),
		.bus_out(bus_out),
		.bus_oe(bus_oe),
		.ctrl_flags(ctrl_flags),
		.nco1_freq(nco1_freq),
		.nco2_freq(nco2_freq),
		.tx_nco_freq(tx_nco_freq),
		.cicfir_gain(cicfir_gain),
		.tx_cicfir_gain(tx_cicfir_gain),
		.dac_gain(dac_gain),
		.adc_offset(adc_offset),
		.vcxo_correction(vcxo_correction),
		.dac_flags(dac_flags),
		.rx_cic_rate(rx_cic_rate),
		.tx_i(tx_i),
		.tx_q(tx_q),
		.tx_iq_valid(tx_iq_valid)
	);

	always #4 adcclk_in = ~adcclk_in;

	task automatic value_error(input string sig, input logic [31:0] expv,
		input logic [31:0] actv);
		errors++;
		$display("Error %s %s: expected %h, actual %h", test_name, sig, expv, actv);
	endtask

	property holds(act, expv);
		@(posedge adcclk_in) disable iff (ADC_MINMAX_RESET) act == expv;
	endproperty

	a_flags : assert property (holds(ctrl_flags, e_flags))
		else value_error("ctrl_flags", $sampled(e_flags), $sampled(ctrl_flags));
	a_nco1 : assert property (holds(nco1_freq, e_nco1))
		else value_error("nco1_freq", $sampled(e_nco1), $sampled(nco1_freq));
	a_nco2 : assert property (holds(nco2_freq, e_nco2))
		else value_error("nco2_freq", $sampled(e_nco2), $sampled(nco2_freq));
	a_txnco : assert property (holds(tx_nco_freq, e_txnco))
		else value_error("tx_nco_freq", $sampled(e_txnco), $sampled(tx_nco_freq));
	a_cicfir : assert property (holds(cicfir_gain, e_cicfir))
		else value_error("cicfir_gain", $sampled(e_cicfir), $sampled(cicfir_gain));
	a_txgain : assert property (holds(tx_cicfir_gain, e_txgain))
		else value_error("tx_cicfir_gain", $sampled(e_txgain), $sampled(tx_cicfir_gain));
	a_dacgain : assert property (holds(dac_gain, e_dacgain))
		else value_error("dac_gain", $sampled(e_dacgain), $sampled(dac_gain));
	a_offset : assert property (holds(adc_offset, e_offset))
		else value_error("adc_offset", $sampled(e_offset), $sampled(adc_offset));
	a_vcxo : assert property (holds(vcxo_correction, e_vcxo))
		else value_error("vcxo_correction", $sampled(e_vcxo), $sampled(vcxo_correction));
	a_dacflags : assert property (holds(dac_flags, e_dacflags))
		else value_error("dac_flags", $sampled(e_dacflags), $sampled(dac_flags));
	a_cic : assert property (holds(rx_cic_rate, e_cic))
		else value_error("rx_cic_rate", $sampled(e_cic), $sampled(rx_cic_rate));
	a_txi : assert property (holds(tx_i, e_txi))
		else value_error("tx_i", $sampled(e_txi), $sampled(tx_i));
	a_txq : assert property (holds(tx_q, e_txq))
		else value_error("tx_q", $sampled(e_txq), $sampled(tx_q));
	a_valid : assert property (holds(tx_iq_valid, e_valid))
		else value_error("tx_iq_valid", $sampled(e_valid), $sampled(tx_iq_valid));
	a_bus_oe : assert property (holds(bus_oe, e_oe))
		else value_error("bus_oe", $sampled(e_oe), $sampled(bus_oe));
	a_bus_out : assert property (@(posedge adcclk_in) disable iff (ADC_MINMAX_RESET)
		e_oe |-> bus_out == e_out)
		else value_error("bus_out", $sampled(e_out), $sampled(bus_out));

	task automatic reset_model();
		e_flags = 8'b0001_0001; // rx1 and adc_shdn
		e_nco1 = 32'd242347;
		e_nco2 = 32'd242347;
		e_txnco = 32'd242347;
		e_cicfir = 8'd32;
		e_txgain = 8'd32;
		e_dacgain = 8'd32;
		e_offset = '0;
		e_vcxo = '0;
		e_dacflags = '0;
		e_cic = 11'd640;
		e_txi = '0;
		e_txq = '0;
		e_valid = 1'b0;
		e_oe = 1'b0;
		e_out = '0;
		m_state = IDLE;
		m_idx = '0;
		m_len = '0;
		w_min = 16'sd32000;
		w_max = -16'sd32000;
		s_min = '0;
		s_max = '0;
		snap_next = 1'b0;
	endtask

	task automatic write_param(input int k, input byte_t b);
		if (k == 0)
		begin
			e_flags = b;
			if (!b[2]) // TX off
			begin
				e_txi = '0;
				e_txq = '0;
				e_valid = 1'b1;
			end
		end
		else if (k <= 4)
			e_nco1[31 - 8 * (k - 1) -: 8] = b;
		else if (k <= 8)
			e_nco2[31 - 8 * (k - 5) -: 8] = b;
		else if (k == 9)
			e_cicfir = b;
		else if (k == 10)
			e_txgain = b;
		else if (k == 11)
			e_dacgain = b;
		else if (k == 12)
			e_offset[15:8] = b;
		else if (k == 13)
			e_offset[7:0] = b;
		else if (k == 14)
			e_vcxo = b;
		else if (k == 15)
		begin
			e_dacflags = b[5:0];
			e_cic = 11'd160 << b[7:6]; // 160, 320, 640, 1280
		end
		else
			e_txnco[31 - 8 * (k - 16) -: 8] = b;
	endtask

	function automatic byte_t status_exp(input int k);
		case (k)
			0: return {6'b0, dac_otr, adc_otr};
			1: return s_min[15:8];
			2: return s_min[7:0];
			3: return s_max[15:8];
			4: return s_max[7:0];
			5: return vcxo_err[23:16];
			6: return vcxo_err[15:8];
			default: return vcxo_err[7:0];
		endcase
	endfunction

	// Effects of one rising edge, given what was on the inputs before it
	task automatic update_model(input logic sync, input byte_t din, input sample_t smp);
		int k;
		k = m_idx;
		if (snap_next)
		begin
			s_min = w_min;
			s_max = w_max;
			w_min = smp;
			w_max = smp;
		end
		else
		begin
			if (smp < w_min)
				w_min = smp;
			if (smp > w_max)
				w_max = smp;
		end
		snap_next = 1'b0;
		e_oe = (m_state == RD_STATUS) || (m_state == RD_INFO) ||
			(m_state == BUS_ECHO && !m_idx[0]);
		if (m_state == RD_STATUS)
			e_out = status_exp(k);
		else if (m_state == RD_INFO)
			e_out = 8'd2 + byte_t'(k);
		else if (m_state == BUS_ECHO && !m_idx[0])
			e_out = din;
		if (!sync && m_state == WR_PARAMS)
			write_param(k, din);
		if (!sync && m_state == WR_TX_IQ)
		begin
			if (k < 4)
				e_txq[31 - 8 * k -: 8] = din;
			else
				e_txi[31 - 8 * (k - 4) -: 8] = din;
			if (k == 7)
				e_valid = 1'b1;
		end
		if (sync)
		begin
			m_idx = '0;
			case (din)
				OP_BUS_TEST: m_state = BUS_ECHO;
				OP_SET_PARAMS: m_state = WR_PARAMS;
				OP_GET_STATUS: m_state = RD_STATUS;
				OP_TX_IQ: m_state = WR_TX_IQ;
				OP_GET_INFO: m_state = RD_INFO;
				default: m_state = IDLE;
			endcase
			m_len = (din == OP_SET_PARAMS) ? 5'd20 : (din == OP_GET_INFO) ? 5'd3 : 5'd8;
			if (din == OP_TX_IQ)
				e_valid = 1'b0;
			snap_next = (din == OP_GET_STATUS);
		end
		else if (m_state != IDLE)
		begin
			if (m_state != BUS_ECHO && m_idx == m_len - 5'd1)
				m_state = IDLE;
			m_idx = m_idx + 5'd1;
		end
	endtask

	// Called 1 ns after an edge, returns 1 ns after the next one
	task automatic tick(input logic sync, input byte_t din);
		sample_t smp;
		smp = sample_t'($random(seed));
		bus_sync = sync;
		bus_in = din;
		adc_in = smp;
		@(posedge adcclk_in);
		#1;
		update_model(sync, din, smp);
	endtask

	task automatic idle(input int n);
		repeat (n)
			tick(1'b0, 8'h00);
	endtask

	task automatic fill_payload(input int n);
		int k;
		for (k = 0; k < n; k++)
			payload[k] = byte_t'($random(seed));
	endtask

	task automatic send_cmd(input byte_t op, input int nbytes);
		int k;
		tick(1'b1, op);
		for (k = 0; k < nbytes; k++)
			tick(1'b0, payload[k]);
	endtask

	task automatic wait_oe_low(input int limit);
		int n;
		n = 0;
		while (bus_oe && n < limit)
		begin
			tick(1'b0, 8'h00);
			n++;
		end
		if (bus_oe)
		begin
			timeouts++;
			$display("Timeout in %s: bus_oe still high after %0d cycles", test_name, limit);
		end
	endtask

	initial
	begin
		int c;
		seed = 24940;
		errors = 0;
		timeouts = 0;
		adcclk_in = 1'b0;
		ADC_MINMAX_RESET = 1'b1;
		bus_sync = 1'b0;
		bus_in = '0;
		adc_in = '0;
		adc_otr = 1'b0;
		dac_otr = 1'b0;
		vcxo_err = '0;
		test_name = "reset";
		reset_model();
		repeat (4)
			@(posedge adcclk_in);
		#1;
		ADC_MINMAX_RESET = 1'b0;
		idle(3);

		test_name = "set_params";
		for (c = 0; c < 4; c++)
		begin
			fill_payload(20);
			payload[0][2] = c[0]; // TX off on even runs
			payload[15][7:6] = c[1:0];
			send_cmd(OP_SET_PARAMS, 20);
			idle(2);
		end

		test_name = "tx_iq";
		fill_payload(8);
		send_cmd(OP_TX_IQ, 8);
		idle(2);

		test_name = "get_status";
		repeat (2)
		begin
			adc_otr = 1'($random(seed));
			dac_otr = 1'($random(seed));
			vcxo_err = vcxo_err_t'($random(seed));
			idle(6);
			send_cmd(OP_GET_STATUS, 8);
			wait_oe_low(4);
		end

		test_name = "bus_test";
		fill_payload(12);
		send_cmd(OP_BUS_TEST, 12);
		test_name = "get_info";
		send_cmd(OP_GET_INFO, 3);
		wait_oe_low(4);

		test_name = "abort";
		fill_payload(20);
		payload[0][2] = 1'b0; // TX off flushes the loaded I/Q pair
		send_cmd(OP_SET_PARAMS, 11);
		send_cmd(8'h5a, 4); // Unknown opcode
		idle(4);

		$display("Summary: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- host_link.f
source/host_link_pkg.sv
source/host_cmd_fsm.sv
source/byte_counter.sv
source/control_regs.sv
source/adc_peak_tracker.sv
source/readback_mux.sv
source/host_link_top.sv
test/host_link_tb.sv
